/* Makefile */
# Verilator build for the LC-3 datapath testbench

VERILATOR ?= verilator
TOP       ?= datapathTb
FILELIST  ?= datapath.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
SIMFLAGS  ?= -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIMFLAGS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* datapath.f */
+incdir+hw
hw/lc3Pkg.sv
hw/regFile.sv
hw/aluUnit.sv
hw/addrUnit.sv
hw/pcUnit.sv
hw/memInterface.sv
hw/branchLogic.sv
hw/datapath.sv
sim/datapath_assert.sv
sim/datapathTb.sv

/* hw/addrUnit.sv */
// Address adder with ADDR1/ADDR2 muxes and offset sign extension
`timescale 1ns/100ps

module addrUnit (
    input  lc3Pkg::word_t     ir,
    input  lc3Pkg::word_t     pc,
    input  lc3Pkg::word_t     sr1,
    input  logic              addr1Mux,
    input  lc3Pkg::addr2Sel_t addr2Mux,
    output lc3Pkg::word_t     addrSum
);
    import lc3Pkg::*;

    word_t base;
    word_t offset;
    word_t sext6;
    word_t sext9;
    word_t sext11;

    assign sext6  = word_t'($signed(ir[5:0]));
    assign sext9  = word_t'($signed(ir[8:0]));
    assign sext11 = word_t'($signed(ir[10:0]));

    // BaseR for LDR/STR/JSRR, PC otherwise
    assign base = addr1Mux ? sr1 : pc;

    always_comb begin
        case (addr2Mux)
            offZero: offset = '0;
            off6:    offset = sext6;
            off9:    offset = sext9;
            off11:   offset = sext11;
        endcase
    end

    // Wraps modulo 2^16
    assign addrSum = base + offset;

endmodule

/* hw/aluUnit.sv */
// ALU with SR2 or immediate-5 second operand
`timescale 1ns/100ps

module aluUnit (
    input  lc3Pkg::word_t  ir,
    input  lc3Pkg::word_t  sr1,
    input  lc3Pkg::word_t  sr2,
    input  logic           sr2Mux,
    input  lc3Pkg::aluOp_t aluK,
    output lc3Pkg::word_t  aluResult
);
    import lc3Pkg::*;

    word_t imm5;
    word_t opB;

    // imm5 from IR[4:0], sign extended
    assign imm5 = word_t'($signed(ir[4:0]));
    assign opB  = sr2Mux ? imm5 : sr2;

    always_comb begin
        case (aluK)
            aluAdd:   aluResult = sr1 + opB;
            aluAnd:   aluResult = sr1 & opB;
            aluNot:   aluResult = ~sr1;
            aluPassA: aluResult = sr1;
        endcase
    end

endmodule

/* hw/branchLogic.sv */
// NZP condition codes and branch-enable register
`timescale 1ns/100ps

module branchLogic (
    input  logic          Clk,
    input  logic          rstN,
    input  logic          ldCc,
    input  logic          ldBen,
    input  lc3Pkg::word_t busIn,
    input  logic [2:0]    irCond,
    output logic          ben
);
    import lc3Pkg::*;

    logic [2:0] nzp;
    logic [2:0] nzpNext;

    // Sign bit first, then zero test
    always_comb begin
        if (busIn[$bits(word_t)-1]) begin
            nzpNext = 3'b100;
        end else if (busIn == '0) begin
            nzpNext = 3'b010;
        end else begin
            nzpNext = 3'b001;
        end
    end

    // BEN uses the codes held before this edge
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            nzp <= 3'b010;
            ben <= 1'b0;
        end else begin
            if (ldCc) begin
                nzp <= nzpNext;
            end
            if (ldBen) begin
                ben <= |(irCond & nzp);
            end
        end
    end

endmodule

/* hw/datapath.sv */
// LC-3 datapath top with IR, LED latch, bus gate mux and unit instances
`timescale 1ns/100ps

module datapath (
    input  logic            Clk,
    input  logic            rstN,
    input  lc3Pkg::dpCtrl_t ctrl,
    input  lc3Pkg::word_t   memRdata,
    output lc3Pkg::memOut_t mem,
    output lc3Pkg::word_t   ir,
    output lc3Pkg::word_t   pc,
    output logic [11:0]     led,
    output logic            ben
);
    import lc3Pkg::*;

    word_t bus;
    word_t sr1;
    word_t sr2;
    word_t aluResult;
    word_t addrSum;

    // One-hot gate mux, nothing gated gives zero
    always_comb begin
        bus = '0;
        if (ctrl.gate.gatePc) begin
            bus |= pc;
        end
        if (ctrl.gate.gateMdr) begin
            bus |= mem.mdr;
        end
        if (ctrl.gate.gateMarMux) begin
            bus |= addrSum;
        end
        if (ctrl.gate.gateAlu) begin
            bus |= aluResult;
        end
    end

    // IR and LED latch
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            ir  <= '0;
            led <= '0;
        end else begin
            if (ctrl.ldIr) begin
                ir <= bus;
            end
            if (ctrl.ldLed) begin
                led <= ir[11:0];
            end
        end
    end

    regFile regFile0 (
        .Clk,
        .rstN,
        .ldReg  (ctrl.ldReg),
        .drMux  (ctrl.drMux),
        .sr1Mux (ctrl.sr1Mux),
        .ir,
        .busIn  (bus),
        .sr1,
        .sr2
    );

    aluUnit aluUnit0 (
        .ir,
        .sr1,
        .sr2,
        .sr2Mux    (ctrl.sr2Mux),
        .aluK      (ctrl.aluK),
        .aluResult
    );

    addrUnit addrUnit0 (
        .ir,
        .pc,
        .sr1,
        .addr1Mux (ctrl.addr1Mux),
        .addr2Mux (ctrl.addr2Mux),
        .addrSum
    );

    pcUnit pcUnit0 (
        .Clk,
        .rstN,
        .ldPc    (ctrl.ldPc),
        .pcMux   (ctrl.pcMux),
        .busIn   (bus),
        .addrSum,
        .pc
    );

    memInterface memInterface0 (
        .Clk,
        .rstN,
        .ldMar    (ctrl.ldMar),
        .ldMdr    (ctrl.ldMdr),
        .mioEn    (ctrl.mioEn),
        .busIn    (bus),
        .memRdata,
        .mem
    );

    // Branch condition bits from IR[11:9]
    branchLogic branchLogic0 (
        .Clk,
        .rstN,
        .ldCc   (ctrl.ldCc),
        .ldBen  (ctrl.ldBen),
        .busIn  (bus),
        .irCond (ir[11:9]),
        .ben
    );

endmodule

/* hw/lc3Pkg.sv */
// Word, ALU operation, control word and memory port types of the LC-3 datapath
`include "lc3_defs.svh"

package lc3Pkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`REG_SEL_WIDTH-1:0] regSel_t;

    typedef enum logic [1:0] {
        aluAdd,
        aluAnd,
        aluNot,
        aluPassA
    } aluOp_t;

    // Fourth code is unused and holds the PC
    typedef enum logic [1:0] {
        pcPlusOne,
        pcFromBus,
        pcFromAdder
    } pcSrc_t;

    typedef enum logic [1:0] {
        offZero,
        off6,
        off9,
        off11
    } addr2Sel_t;

    // One-hot bus drivers, at most one set
    typedef struct packed {
        logic gatePc;
        logic gateMdr;
        logic gateMarMux;
        logic gateAlu;
    } gateSel_t;

    // Full control word from the FSM
    typedef struct packed {
        logic      ldPc;
        logic      ldMdr;
        logic      ldMar;
        logic      ldIr;
        logic      ldBen;
        logic      ldCc;
        logic      ldReg;
        logic      ldLed;
        logic      mioEn;
        gateSel_t  gate;
        pcSrc_t    pcMux;
        addr2Sel_t addr2Mux;
        aluOp_t    aluK;
        logic      drMux;
        logic      sr1Mux;
        logic      sr2Mux;
        logic      addr1Mux;
    } dpCtrl_t;

    typedef struct packed {
        word_t mar;
        word_t mdr;
    } memOut_t;

endpackage

/* hw/lc3_defs.svh */
// Word width and register file sizing for the LC-3 datapath
`ifndef LC3_DEFS_SVH
`define LC3_DEFS_SVH

// Data and address width
`define WORD_WIDTH 16

// General purpose registers R0 to R7
`define NUM_REGS 8

// Index width for one register of the file
`define REG_SEL_WIDTH 3

`endif

/* hw/memInterface.sv */
// MAR and MDR registers with the MDR memory-or-bus select
`timescale 1ns/100ps

module memInterface (
    input  logic            Clk,
    input  logic            rstN,
    input  logic            ldMar,
    input  logic            ldMdr,
    input  logic            mioEn,
    input  lc3Pkg::word_t   busIn,
    input  lc3Pkg::word_t   memRdata,
    output lc3Pkg::memOut_t mem
);
    import lc3Pkg::*;

    word_t marReg;
    word_t mdrReg;
    word_t mdrIn;

    // Read data on memory cycles, bus on stores
    assign mdrIn = mioEn ? memRdata : busIn;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            marReg <= '0;
            mdrReg <= '0;
        end else begin
            if (ldMar) begin
                marReg <= busIn;
            end
            if (ldMdr) begin
                mdrReg <= mdrIn;
            end
        end
    end

    assign mem = '{mar: marReg, mdr: mdrReg};

endmodule

/* hw/pcUnit.sv */
// Program counter with incrementer and source mux
`timescale 1ns/100ps

module pcUnit (
    input  logic           Clk,
    input  logic           rstN,
    input  logic           ldPc,
    input  lc3Pkg::pcSrc_t pcMux,
    input  lc3Pkg::word_t  busIn,
    input  lc3Pkg::word_t  addrSum,
    output lc3Pkg::word_t  pc
);
    import lc3Pkg::*;

    word_t pcNext;

    always_comb begin
        case (pcMux)
            pcPlusOne:   pcNext = pc + 1'b1;
            pcFromBus:   pcNext = busIn;
            pcFromAdder: pcNext = addrSum;
            default:     pcNext = pc;
        endcase
    end

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (ldPc) begin
            pc <= pcNext;
        end
    end

endmodule

/* hw/regFile.sv */
// Eight-entry register file with IR-field register selects
`timescale 1ns/100ps
`include "lc3_defs.svh"

module regFile (
    input  logic          Clk,
    input  logic          rstN,
    input  logic          ldReg,
    input  logic          drMux,
    input  logic          sr1Mux,
    input  lc3Pkg::word_t ir,
    input  lc3Pkg::word_t busIn,
    output lc3Pkg::word_t sr1,
    output lc3Pkg::word_t sr2
);
    import lc3Pkg::*;

    word_t   regs [`NUM_REGS];
    regSel_t drSel;
    regSel_t sr1Sel;
    regSel_t sr2Sel;

    // DR is R7 for JSR/TRAP linkage
    assign drSel  = drMux ? regSel_t'(`NUM_REGS - 1) : ir[11:9];
    assign sr1Sel = sr1Mux ? ir[11:9] : ir[8:6];
    assign sr2Sel = ir[2:0];

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ldReg) begin
            regs[drSel] <= busIn;
        end
    end

    assign sr1 = regs[sr1Sel];
    assign sr2 = regs[sr2Sel];

endmodule

/* sim/datapathTb.sv */
// Testbench for the LC-3 datapath with seeded random control words and a reference model
`timescale 1ns/100ps

module datapathTb;
    import lc3Pkg::*;

    localparam int RESET_TIMEOUT = 20;
    localparam int BEN_LOADS     = 1000;
    localparam int RUN_TIMEOUT   = 4000;

    logic        Clk;
    logic        rstN;
    dpCtrl_t     ctrl;
    word_t       memRdata;
    memOut_t     mem;
    word_t       ir;
    word_t       pc;
    logic [11:0] led;
    logic        ben;

    integer seed;
    int     cycles;
    int     benLoads;

    // Model state
    word_t       mPc;
    word_t       mMar;
    word_t       mMdr;
    word_t       mIr;
    logic [11:0] mLed;
    word_t       mRegs [8];
    logic [2:0]  mNzp;
    logic        mBen;

    datapath dut0 (
        .Clk      (Clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .memRdata (memRdata),
        .mem      (mem),
        .ir       (ir),
        .pc       (pc),
        .led      (led),
        .ben      (ben)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
    end

    task automatic abortRun(input string why);
        $display("Testbench failed");
        $fatal(1, "%s", why);
    endtask

    task automatic checkWord(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            abortRun("word mismatch");
        end
    endtask

    task automatic checkMem(input memOut_t exp, input memOut_t act);
        if (exp !== act) begin
            $display("** Error at %0t: mem expected mar %h mdr %h, got mar %h mdr %h",
                     $time, exp.mar, exp.mdr, act.mar, act.mdr);
            abortRun("memory port mismatch");
        end
    endtask

    task automatic checkLed(input logic [11:0] exp, input logic [11:0] act);
        if (exp !== act) begin
            $display("** Error at %0t: led expected %h, got %h", $time, exp, act);
            abortRun("led mismatch");
        end
    endtask

    task automatic checkBen(input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error at %0t: ben expected %b, got %b", $time, exp, act);
            abortRun("ben mismatch");
        end
    endtask

    task automatic checkAll();
        checkWord("pc", mPc, pc);
        checkWord("ir", mIr, ir);
        checkMem(memOut_t'{mar: mMar, mdr: mMdr}, mem);
        checkLed(mLed, led);
        checkBen(mBen, ben);
    endtask

    task automatic resetModel();
        mPc  = '0;
        mMar = '0;
        mMdr = '0;
        mIr  = '0;
        mLed = '0;
        for (int i = 0; i < 8; i++) begin
            mRegs[i] = '0;
        end
        mNzp = 3'b010;
        mBen = 1'b0;
    endtask

    // One rising edge of the model from the state before the edge
    task automatic stepModel(input dpCtrl_t c, input word_t rd);
        word_t opA;
        word_t opB;
        word_t alu;
        word_t base;
        word_t off;
        word_t sum;
        word_t bus;
        logic [2:0] dr;
        opA = mRegs[c.sr1Mux ? mIr[11:9] : mIr[8:6]];
        opB = c.sr2Mux ? {{11{mIr[4]}}, mIr[4:0]} : mRegs[mIr[2:0]];
        case (c.aluK)
            aluAdd:  alu = opA + opB;
            aluAnd:  alu = opA & opB;
            aluNot:  alu = ~opA;
            default: alu = opA;
        endcase
        base = c.addr1Mux ? opA : mPc;
        case (c.addr2Mux)
            offZero: off = '0;
            off6:    off = {{10{mIr[5]}}, mIr[5:0]};
            off9:    off = {{7{mIr[8]}}, mIr[8:0]};
            default: off = {{5{mIr[10]}}, mIr[10:0]};
        endcase
        sum = base + off;
        if (c.gate.gatePc) bus = mPc;
        else if (c.gate.gateMdr) bus = mMdr;
        else if (c.gate.gateMarMux) bus = sum;
        else if (c.gate.gateAlu) bus = alu;
        else bus = '0;
        dr = c.drMux ? 3'd7 : mIr[11:9];
        // n with N, z with Z, p with P
        if (c.ldBen) begin
            mBen = (mIr[11] & mNzp[2]) | (mIr[10] & mNzp[1]) | (mIr[9] & mNzp[0]);
        end
        if (c.ldCc) mNzp = bus[15] ? 3'b100 : (bus == '0 ? 3'b010 : 3'b001);
        if (c.ldLed) mLed = mIr[11:0];
        if (c.ldReg) mRegs[dr] = bus;
        if (c.ldMar) mMar = bus;
        if (c.ldMdr) mMdr = c.mioEn ? rd : bus;
        if (c.ldIr) mIr = bus;
        if (c.ldPc) begin
            case (c.pcMux)
                pcPlusOne:   mPc = mPc + 16'd1;
                pcFromBus:   mPc = bus;
                pcFromAdder: mPc = sum;
                default:     mPc = mPc;
            endcase
        end
    endtask

    // Called at a falling edge and checks after the next rising edge
    task automatic driveCycle(input dpCtrl_t c, input word_t rd);
        ctrl     = c;
        memRdata = rd;
        stepModel(c, rd);
        @(negedge Clk);
        checkAll();
    endtask

    // Random control word with at most one gate bit
    function automatic dpCtrl_t randomCtrl();
        dpCtrl_t c;
        logic [31:0] r;
        int pick;
        r = $random(seed);
        c = r[$bits(dpCtrl_t)-1:0];
        pick = {$random(seed)} % 5;
        c.gate = (pick == 0) ? gateSel_t'(4'b0000) : gateSel_t'(4'b1000 >> (pick - 1));
        return c;
    endfunction

    // Writes val into R[n] through MDR and IR
    task automatic seedReg(input logic [2:0] n, input word_t val);
        dpCtrl_t c;
        c = '0;
        c.ldMdr = 1'b1;
        c.mioEn = 1'b1;
        driveCycle(c, {4'h1, n, 9'h0});
        c = '0;
        c.gate.gateMdr = 1'b1;
        c.ldIr = 1'b1;
        driveCycle(c, '0);
        c = '0;
        c.ldMdr = 1'b1;
        c.mioEn = 1'b1;
        driveCycle(c, val);
        c = '0;
        c.gate.gateMdr = 1'b1;
        c.ldReg = 1'b1;
        c.ldCc = 1'b1;
        driveCycle(c, '0);
    endtask

    initial begin
        dpCtrl_t c;
        word_t rd;
        seed = 20489;
        ctrl = '0;
        memRdata = '0;
        resetModel();
        cycles = 0;
        while (rstN !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge Clk);
            cycles++;
        end
        if (rstN !== 1'b1) begin
            $display("Timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
            abortRun("reset timeout");
        end else begin
            @(negedge Clk);
            checkAll();
            for (int i = 0; i < 8; i++) begin
                seedReg(3'(i), word_t'($random(seed)));
            end
            benLoads = 0;
            cycles = 0;
            while (benLoads < BEN_LOADS && cycles < RUN_TIMEOUT) begin
                c = randomCtrl();
                rd = word_t'($random(seed));
                driveCycle(c, rd);
                if (c.ldBen) benLoads++;
                cycles++;
            end
            if (benLoads < BEN_LOADS) begin
                $display("Timeout: only %0d BEN loads in %0d cycles", benLoads, cycles);
                abortRun("run timeout");
            end else begin
                $display("Testbench passed");
                $finish;
            end
        end
    end

endmodule

/* sim/datapath_assert.sv */
// Concurrent assertions on bus gating, PC hold and MAR reset, bound to datapath
`timescale 1ns/100ps

module datapath_assert (
    input logic            Clk,
    input logic            rstN,
    input lc3Pkg::dpCtrl_t ctrl,
    input lc3Pkg::word_t   pc,
    input lc3Pkg::memOut_t mem
);
    import lc3Pkg::*;

    // At most one bus driver
    gateOneHot: assert property (@(posedge Clk) $onehot0(ctrl.gate))
        else $error("more than one bus gate active");

    // PC is stable without a load
    pcHold: assert property (@(posedge Clk) (rstN && !ctrl.ldPc) |=> (pc == $past(pc)))
        else $error("pc changed while ldPc was low");

    marReset: assert property (@(posedge Clk) !rstN |=> (mem.mar == '0))
        else $error("mar not cleared after reset");

endmodule

bind datapath datapath_assert assert0 (
    .Clk  (Clk),
    .rstN (rstN),
    .ctrl (ctrl),
    .pc   (pc),
    .mem  (mem)
);
